// File: include/feeder_consts.svh
`ifndef FEEDER_CONSTS_SVH
`define FEEDER_CONSTS_SVH

////////////////////
// Widths
////////////////////

// Raster row and line counters
`define FEEDER_COORD_BITS 11

// One BGR pixel, 8 bits per channel
`define FEEDER_PIXEL_BITS 24

// One RAM word carries a whole block of pixels
`define FEEDER_SLOTS 256
`define FEEDER_BLOCK_BITS 6144

////////////////////
// Display window
////////////////////

// Active columns, limit is exclusive
`define FEEDER_ROW_FIRST 279
`define FEEDER_ROW_LIMIT 1303

// Active lines, limit is exclusive
`define FEEDER_LINE_FIRST 35
`define FEEDER_LINE_LIMIT 803

// Frame mark sits on the line before the first active one
`define FEEDER_MARK_LINE 34
`define FEEDER_MARK_ROW_LIMIT 282

////////////////////
// Slot events
////////////////////

// Fetch level window for the RAM request
`define FEEDER_FETCH_ON 10
`define FEEDER_FETCH_OFF 13

// Bank flips
`define FEEDER_FILL_SLOT 11
`define FEEDER_TURN_SLOT 255

`endif

// File: rtl/feeder_pkg.sv
`default_nettype none

`include "feeder_consts.svh"

package feeder_pkg;

	////////////////////
	// Plain vectors
	////////////////////

	// Row or line number
	typedef logic [`FEEDER_COORD_BITS-1:0] coord_t;

	// BGR pixel, blue in the top byte
	typedef logic [`FEEDER_PIXEL_BITS-1:0] pixel_t;

	// Index of a pixel inside a block
	typedef logic [$clog2(`FEEDER_SLOTS)-1:0] slot_t;

	// Slot 0 sits in the most significant pixel
	typedef logic [`FEEDER_BLOCK_BITS-1:0] block_t;

	////////////////////
	// Bundles
	////////////////////

	// Raster position from the video timing
	typedef struct packed {
		coord_t row;
		coord_t line;
	} raster_pos_t;

	// Per-cycle decode shared by the banks and the unpacker
	typedef struct packed {
		logic active;
		slot_t slot;
		logic fill_flip;
		logic turn_flip;
	} scan_ctrl_t;

	////////////////////
	// Pulse machine
	////////////////////

	typedef enum logic [1:0] {
		REQ_IDLE,
		REQ_ARMED,
		REQ_FIRE
	} req_state_t;

endpackage

`default_nettype wire

// File: rtl/scan_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "feeder_consts.svh"

module scan_counter (
	input logic clk125,
	input logic reset,
	input feeder_pkg::raster_pos_t pos,
	output feeder_pkg::scan_ctrl_t scan,
	output logic fetch,
	output logic frame_mark
);

	import feeder_pkg::*;

	slot_t slot_count;
	logic row_active;
	logic line_active;
	logic in_window;
	logic mark_hit;
	logic fetch_set;
	logic fetch_clear;

	////////////////////
	// Window decode
	////////////////////

	assign row_active = (pos.row >= coord_t'(`FEEDER_ROW_FIRST)) &&
		(pos.row < coord_t'(`FEEDER_ROW_LIMIT));

	assign line_active = (pos.line >= coord_t'(`FEEDER_LINE_FIRST)) &&
		(pos.line < coord_t'(`FEEDER_LINE_LIMIT));

	assign in_window = row_active && line_active;

	// Three rows at the start of the mark line
	assign mark_hit = (pos.line == coord_t'(`FEEDER_MARK_LINE)) &&
		(pos.row >= coord_t'(`FEEDER_ROW_FIRST)) &&
		(pos.row < coord_t'(`FEEDER_MARK_ROW_LIMIT));

	////////////////////
	// Slot events
	////////////////////

	assign fetch_set = in_window && (slot_count == slot_t'(`FEEDER_FETCH_ON));
	assign fetch_clear = in_window && (slot_count == slot_t'(`FEEDER_FETCH_OFF));

	always_comb begin
		scan.active = in_window;
		scan.slot = slot_count;
		scan.fill_flip = in_window && (slot_count == slot_t'(`FEEDER_FILL_SLOT));
		scan.turn_flip = in_window && (slot_count == slot_t'(`FEEDER_TURN_SLOT));
	end

	////////////////////
	// Registers
	////////////////////

	// Steps only on active pixels, wraps at the block end
	always_ff @(posedge clk125) begin
		if (reset) begin
			slot_count <= '0;
		end else if (in_window) begin
			slot_count <= slot_t'(slot_count + 1'b1);
		end
	end

	// Level holds through blanking until the clear slot
	always_ff @(posedge clk125) begin
		if (reset) begin
			fetch <= 1'b0;
		end else if (fetch_set) begin
			fetch <= 1'b1;
		end else if (fetch_clear) begin
			fetch <= 1'b0;
		end
	end

	always_ff @(posedge clk125) begin
		if (reset) begin
			frame_mark <= 1'b0;
		end else begin
			frame_mark <= mark_hit;
		end
	end

endmodule

`default_nettype wire

// File: rtl/req_pulse_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module req_pulse_fsm (
	input logic clk125,
	input logic reset,
	input logic window,
	output logic pulse
);

	import feeder_pkg::*;

	req_state_t state;
	req_state_t state_next;

	////////////////////
	// Next state
	////////////////////

	always_comb begin
		state_next = state;
		case (state)
			REQ_IDLE: begin
				if (window) begin
					state_next = REQ_ARMED;
				end
			end
			REQ_ARMED: begin
				// Wait for the strobe window to close
				if (!window) begin
					state_next = REQ_FIRE;
				end
			end
			REQ_FIRE: begin
				state_next = REQ_IDLE;
			end
			default: begin
				state_next = REQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk125) begin
		if (reset) begin
			state <= REQ_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Registered so the output is glitch free at the RAM side
	always_ff @(posedge clk125) begin
		if (reset) begin
			pulse <= 1'b0;
		end else begin
			pulse <= (state == REQ_FIRE);
		end
	end

endmodule

`default_nettype wire

// File: rtl/bank_store.sv
`timescale 1ns/1ps
`default_nettype none

module bank_store (
	input logic clk125,
	input logic reset,
	input feeder_pkg::scan_ctrl_t scan,
	input feeder_pkg::block_t block,
	output feeder_pkg::block_t read_block
);

	import feeder_pkg::*;

	block_t bank_1;
	block_t bank_2;
	logic fill_sel;
	logic read_sel;

	////////////////////
	// Bank select flags
	////////////////////

	always_ff @(posedge clk125) begin
		if (reset) begin
			fill_sel <= 1'b0;
			read_sel <= 1'b0;
		end else begin
			if (scan.fill_flip) begin
				fill_sel <= ~fill_sel;
			end
			if (scan.turn_flip) begin
				read_sel <= ~read_sel;
			end
		end
	end

	////////////////////
	// Storage
	////////////////////

	// RAM word is sampled every cycle into the bank not being filled last
	always_ff @(posedge clk125) begin
		if (reset) begin
			bank_1 <= '0;
			bank_2 <= '0;
		end else if (fill_sel) begin
			bank_2 <= block;
		end else begin
			bank_1 <= block;
		end
	end

	assign read_block = read_sel ? bank_2 : bank_1;

endmodule

`default_nettype wire

// File: rtl/pixel_unpack.sv
`timescale 1ns/1ps
`default_nettype none

`include "feeder_consts.svh"

module pixel_unpack (
	input logic clk125,
	input logic reset,
	input feeder_pkg::scan_ctrl_t scan,
	input feeder_pkg::block_t read_block,
	output feeder_pkg::pixel_t bgr
);

	import feeder_pkg::*;

	slot_t rev_slot;
	logic [$clog2(`FEEDER_BLOCK_BITS)-1:0] field_base;
	pixel_t field;

	////////////////////
	// Field select
	////////////////////

	// Slot 0 is at the top of the word, so count from the far end
	assign rev_slot = slot_t'(`FEEDER_SLOTS - 1) - scan.slot;

	assign field_base = $bits(field_base)'(rev_slot) *
		$bits(field_base)'(`FEEDER_PIXEL_BITS);

	assign field = read_block[field_base +: `FEEDER_PIXEL_BITS];

	////////////////////
	// Output register
	////////////////////

	// Black outside the active window
	always_ff @(posedge clk125) begin
		if (reset) begin
			bgr <= '0;
		end else if (scan.active) begin
			bgr <= field;
		end else begin
			bgr <= '0;
		end
	end

endmodule

`default_nettype wire

// File: rtl/line_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module line_feeder (
	input logic clk125,
	input logic reset,
	input feeder_pkg::raster_pos_t pos,
	input feeder_pkg::block_t block,
	output feeder_pkg::pixel_t bgr,
	output logic ram_ask,
	output logic new_frame
);

	import feeder_pkg::*;

	scan_ctrl_t scan;
	block_t read_block;
	logic fetch;
	logic frame_mark;

	////////////////////
	// Raster decode
	////////////////////

	scan_counter u_scan (
		.clk125(clk125),
		.reset(reset),
		.pos(pos),
		.scan(scan),
		.fetch(fetch),
		.frame_mark(frame_mark)
	);

	////////////////////
	// Pixel path
	////////////////////

	bank_store u_banks (
		.clk125(clk125),
		.reset(reset),
		.scan(scan),
		.block(block),
		.read_block(read_block)
	);

	pixel_unpack u_unpack (
		.clk125(clk125),
		.reset(reset),
		.scan(scan),
		.read_block(read_block),
		.bgr(bgr)
	);

	////////////////////
	// Pulses
	////////////////////

	// One RAM read per block
	req_pulse_fsm u_ram_req (
		.clk125(clk125),
		.reset(reset),
		.window(fetch),
		.pulse(ram_ask)
	);

	// Frame start, just ahead of the first active line
	req_pulse_fsm u_frame_req (
		.clk125(clk125),
		.reset(reset),
		.window(frame_mark),
		.pulse(new_frame)
	);

endmodule

`default_nettype wire

// File: test/line_feeder_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "feeder_consts.svh"

module line_feeder_props (
	input logic clk125,
	input logic reset,
	input feeder_pkg::raster_pos_t pos,
	input feeder_pkg::pixel_t bgr,
	input logic ram_ask,
	input logic new_frame
);

	import feeder_pkg::*;

	int fail_count = 0;
	logic outside;

	assign outside = !(pos.row >= `FEEDER_ROW_FIRST && pos.row < `FEEDER_ROW_LIMIT &&
		pos.line >= `FEEDER_LINE_FIRST && pos.line < `FEEDER_LINE_LIMIT);

	// Both pulses last one cycle
	ask_single: assert property (@(posedge clk125) disable iff (reset)
		ram_ask |=> !ram_ask)
	else begin
		$error("ram_ask stayed high for two cycles");
		fail_count++;
	end

	frame_single: assert property (@(posedge clk125) disable iff (reset)
		new_frame |=> !new_frame)
	else begin
		$error("new_frame stayed high for two cycles");
		fail_count++;
	end

	// Blanking outside the window
	blank_out: assert property (@(posedge clk125) disable iff (reset)
		outside |=> bgr == '0)
	else begin
		$error("bgr not blank after a cycle outside the window");
		fail_count++;
	end

endmodule

`default_nettype wire

// File: test/line_feeder_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "feeder_consts.svh"

module line_feeder_checker (
	input logic clk125,
	input logic reset,
	input feeder_pkg::raster_pos_t pos,
	input feeder_pkg::block_t block,
	input feeder_pkg::pixel_t bgr,
	input logic ram_ask,
	input logic new_frame
);

	import feeder_pkg::*;

	int bgr_errors = 0;
	int ask_errors = 0;
	int frame_errors = 0;

	// Banks modeled by the tag they last took
	logic [15:0] bank_tag [2];
	logic [1:0] bank_loaded;
	logic fill_bank;
	logic read_bank;
	slot_t slot;
	logic active;
	pixel_t exp_bgr;

	bit seg_open = 1'b0;
	int seg_index;
	logic [15:0] seg_tag;
	int ask_expected;
	int frame_expected;
	int ask_seen;
	int frame_seen;

	function automatic logic in_window(input raster_pos_t p);
		return p.row >= `FEEDER_ROW_FIRST && p.row < `FEEDER_ROW_LIMIT &&
			p.line >= `FEEDER_LINE_FIRST && p.line < `FEEDER_LINE_LIMIT;
	endfunction

	////////////////////
	// Reference model
	////////////////////

	always @(posedge clk125) begin
		if (reset) begin
			bank_loaded = 2'b00;
			fill_bank = 1'b0;
			read_bank = 1'b0;
			slot = '0;
			exp_bgr = '0;
		end else begin
			active = in_window(pos);
			if (active && bank_loaded[read_bank]) begin
				exp_bgr = {bank_tag[read_bank], slot};
			end else begin
				exp_bgr = '0;
			end
			// Fill bank takes the RAM word every clock
			bank_tag[fill_bank] = block[`FEEDER_BLOCK_BITS-1 -: 16];
			bank_loaded[fill_bank] = 1'b1;
			if (active && slot == slot_t'(`FEEDER_FILL_SLOT)) begin
				fill_bank = ~fill_bank;
			end
			if (active && slot == slot_t'(`FEEDER_TURN_SLOT)) begin
				read_bank = ~read_bank;
			end
			if (active) begin
				slot = slot_t'(slot + 1);
			end
		end
	end

	always @(negedge clk125) begin
		if (!reset) begin
			if (bgr !== exp_bgr) begin
				$display("Error: bgr at %0t ns expected %h got %h", $time, exp_bgr, bgr);
				bgr_errors++;
			end
			if (seg_open && ram_ask === 1'b1) begin
				ask_seen++;
			end
			if (seg_open && new_frame === 1'b1) begin
				frame_seen++;
			end
		end
	end

	////////////////////
	// Segment bookkeeping
	////////////////////

	task automatic check_counts();
		if (seg_open) begin
			if (ask_seen != ask_expected) begin
				$display("Error: ram_ask pulses in segment %0d tag %h expected %h got %h",
					seg_index, seg_tag, ask_expected, ask_seen);
				ask_errors++;
			end
			if (frame_seen != frame_expected) begin
				$display("Error: new_frame pulses in segment %0d tag %h expected %h got %h",
					seg_index, seg_tag, frame_expected, frame_seen);
				frame_errors++;
			end
		end
	endtask

	task automatic begin_segment(input int index, input logic [15:0] tag, input int ask,
		input int frame);
		check_counts();
		seg_open = 1'b1;
		seg_index = index;
		seg_tag = tag;
		ask_expected = ask;
		frame_expected = frame;
		ask_seen = 0;
		frame_seen = 0;
	endtask

	task automatic end_run();
		check_counts();
		seg_open = 1'b0;
	endtask

endmodule

`default_nettype wire

// File: test/line_feeder_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "feeder_consts.svh"

module line_feeder_tb;

	import feeder_pkg::*;

	logic clk125 = 1'b0;
	logic reset;
	raster_pos_t pos;
	block_t block;
	pixel_t bgr;
	logic ram_ask;
	logic new_frame;

	int seg_cycles[$];
	int seg_row[$];
	int seg_line[$];
	logic [15:0] seg_tag[$];
	int seg_ask[$];
	int seg_frame[$];
	int total_cycles = 0;
	int setup_errors = 0;
	bit loaded = 1'b0;
	logic [31:0] lfsr_state;

	line_feeder line_feeder_inst (.*);

	line_feeder_checker checker_inst (.*);

	bind line_feeder line_feeder_props props_inst (.*);

	always #5 clk125 = ~clk125;

	////////////////////
	// Stimulus helpers
	////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	// One LFSR step per tag bit
	task automatic draw_tag(output logic [15:0] tag);
		for (int b = 0; b < 16; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			tag = {tag[14:0], lfsr_state[0]};
		end
	endtask

	// Slot k carries the tag and then k, slot 0 on top
	function automatic block_t make_block(input logic [15:0] tag);
		block_t blk;
		for (int k = 0; k < `FEEDER_SLOTS; k++) begin
			blk[`FEEDER_BLOCK_BITS - 1 - k * `FEEDER_PIXEL_BITS -: `FEEDER_PIXEL_BITS] = {tag, 8'(k)};
		end
		return blk;
	endfunction

	task automatic load_golden();
		int fd;
		int n;
		int cycles;
		int row;
		int line;
		int ask;
		int frame;
		logic [15:0] tag;
		logic [8*128-1:0] text;
		fd = $fopen("test/line_feeder_golden.txt", "r");
		if (fd == 0) begin
			$display("Could not open test/line_feeder_golden.txt");
			setup_errors++;
		end else begin
			while (!$feof(fd)) begin
				text = '0;
				n = $fgets(text, fd);
				n = $sscanf(text, "%d %d %d %h %d %d", cycles, row, line, tag, ask, frame);
				if (n == 6) begin
					if (tag == 16'h0) begin
						draw_tag(tag);
					end
					seg_cycles.push_back(cycles);
					seg_row.push_back(row);
					seg_line.push_back(line);
					seg_tag.push_back(tag);
					seg_ask.push_back(ask);
					seg_frame.push_back(frame);
					total_cycles += cycles;
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_segments();
		block_t blk;
		@(posedge clk125);
		block <= make_block(seg_tag[0]);
		repeat (3) @(posedge clk125);
		reset <= 1'b0;
		for (int r = 0; r < seg_cycles.size(); r++) begin
			blk = make_block(seg_tag[r]);
			for (int i = 0; i < seg_cycles[r]; i++) begin
				@(posedge clk125);
				if (i == 0) begin
					checker_inst.begin_segment(r, seg_tag[r], seg_ask[r], seg_frame[r]);
				end
				pos.row <= coord_t'(seg_row[r] + i);
				pos.line <= coord_t'(seg_line[r]);
				block <= blk;
			end
		end
		@(posedge clk125);
		pos <= '0;
		// Let late pulses land
		repeat (8) @(posedge clk125);
		checker_inst.end_run();
	endtask

	////////////////////
	// Main flow
	////////////////////

	initial begin
		int errors;
		reset = 1'b1;
		pos = '0;
		block = '0;
		lfsr_state = 32'h1141_f557;
		load_golden();
		if (seg_cycles.size() == 0) begin
			$display("No segment records were read from the golden file");
			setup_errors++;
		end else begin
			loaded = 1'b1;
			run_segments();
		end
		errors = checker_inst.bgr_errors + checker_inst.ask_errors + checker_inst.frame_errors +
			line_feeder_inst.props_inst.fail_count + setup_errors;
		$display("Errors: bgr %0d, ram_ask %0d, new_frame %0d, assertions %0d, setup %0d",
			checker_inst.bgr_errors, checker_inst.ask_errors, checker_inst.frame_errors,
			line_feeder_inst.props_inst.fail_count, setup_errors);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	initial begin
		wait (loaded);
		#((total_cycles + 100) * 10);
		$display("Watchdog expired before the last segment completed");
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/line_feeder_golden.txt
# cycles start_row line tag(hex, 0 draws from the LFSR) ram_ask_pulses new_frame_pulses
# One segment per record, row steps by one each cycle, line held
40 0 100 1111 0 0
40 1400 100 2222 0 0
40 300 900 3333 0 0
30 270 34 4444 0 1
30 270 33 5555 0 0
520 279 100 a1b2 2 0
150 1200 200 0 1 0
200 279 400 0c0d 1 0
60 1280 802 0 0 0
60 1280 803 7777 0 0
250 279 500 0 1 0

// File: list.f
+incdir+include
rtl/feeder_pkg.sv
rtl/scan_counter.sv
rtl/req_pulse_fsm.sv
rtl/bank_store.sv
rtl/pixel_unpack.sv
rtl/line_feeder.sv
test/line_feeder_props.sv
test/line_feeder_checker.sv
test/line_feeder_tb.sv
